//--- verilog/keyExp_defs.svh
// AES key expansion word and block widths, round-key counts, credit depth, round-constant seed
`ifndef KEY_EXP_DEFS_SVH
`define KEY_EXP_DEFS_SVH

// ====================
// datapath widths
// ====================
// one AES word
`define KEY_WORD_BITS 32
// one round key, four words
`define KEY_BLOCK_BITS 128
// widest cipher key, also the expansion window
`define KEY_MAX_BITS 256

// ====================
// schedule lengths
// ====================
// round keys per cipher key length
`define ROUNDS_128 11
`define ROUNDS_256 15

// consumer credit grant and counter width
`define KEY_CREDITS 4
`define KEY_CREDIT_BITS 3

// one GF(2^8) doubling turns this into the first constant 01
`define RCON_SEED 8'h8d

`endif

//--- verilog/keyExpPkg.sv
// key-expansion types for words, blocks, key window, round index, phase and round constant
`default_nettype none

package keyExpPkg;

  `include "keyExp_defs.svh"

  // one expanded-key word
  typedef logic [`KEY_WORD_BITS-1:0] wordT;

  // one round key
  typedef logic [`KEY_BLOCK_BITS-1:0] blockT;

  // expansion window
  // a 128-bit key sits in the upper half
  typedef logic [`KEY_MAX_BITS-1:0] keyMaterialT;

  // round-key number 0..14
  typedef logic [3:0] roundIndexT;

  // 256-bit alternation between rot/rcon steps and plain sub steps
  typedef enum logic {
    rotPhase = 1'b0,
    subPhase = 1'b1
  } keyPhaseT;

  // leading byte of the round constant word
  typedef logic [7:0] rconT;

endpackage

`default_nettype wire

//--- verilog/keyStepIf.sv
// expansion-state interface between the schedule sequencer and the round-step logic
`timescale 1ns/100ps
`default_nettype none

interface keyStepIf;

  // ====================
  // sequencer to step
  // ====================
  // current expansion window and round constant
  keyExpPkg::keyMaterialT window;
  keyExpPkg::rconT rcon;
  // alternation state, only meaningful for 256-bit keys
  keyExpPkg::keyPhaseT phase;
  // high for a 256-bit key
  logic wideKey;

  // ====================
  // step to sequencer
  // ====================
  // combinational, settles inside the same cycle
  keyExpPkg::keyMaterialT nextWindow;
  keyExpPkg::rconT nextRcon;

  modport sequencer (
    output window, rcon, phase, wideKey,
    input  nextWindow, nextRcon
  );

  modport step (
    input  window, rcon, phase, wideKey,
    output nextWindow, nextRcon
  );

endinterface

`default_nettype wire

//--- verilog/subWord.sv
// forward AES S-box substitution on each byte of one word
`timescale 1ns/100ps
`default_nettype none

module subWord (
  input  keyExpPkg::wordT in,
  output keyExpPkg::wordT out
);
  import keyExpPkg::*;

  localparam int WordBytes = $bits(wordT) / 8;

  // ====================
  // forward S-box
  // ====================
  // indexed by the input byte value
  localparam logic [7:0] SBox [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // ====================
  // byte lanes
  // ====================
  // four independent lookups, no mixing between bytes
  always_comb begin
    for (int b = 0; b < WordBytes; b++) begin
      out[8*b +: 8] = SBox[in[8*b +: 8]];
    end
  end

endmodule

`default_nettype wire

//--- verilog/keyStep.sv
// combinational AES round-key step: next window and next round constant for 128/256-bit keys
`timescale 1ns/100ps
`default_nettype none

`include "keyExp_defs.svh"

module keyStep (
  keyStepIf.step stepBus
);
  import keyExpPkg::*;

  logic advance;
  rconT doubledRcon;
  rconT rconOut;
  blockT upperBlock;
  blockT newBlock;
  wordT lastWord;
  wordT rotatedWord;
  wordT subIn;
  wordT subOut;
  wordT mixWord;

  // ====================
  // round constant
  // ====================
  // every 128-bit step and every rot step of a 256-bit key moves the constant
  assign advance = !stepBus.wideKey || (stepBus.phase == rotPhase);

  // xtime, reduce by the AES polynomial on carry out
  assign doubledRcon = {stepBus.rcon[6:0], 1'b0} ^ (stepBus.rcon[7] ? 8'h1b : 8'h00);
  assign rconOut = advance ? doubledRcon : stepBus.rcon;
  assign stepBus.nextRcon = rconOut;

  // ====================
  // substituted word
  // ====================
  // upper four words are the round key being shown
  assign upperBlock = stepBus.window[`KEY_MAX_BITS-1 -: `KEY_BLOCK_BITS];

  // 128-bit: last word of the round key
  // 256-bit: lowest word of the whole window
  assign lastWord = stepBus.wideKey ? stepBus.window[`KEY_WORD_BITS-1:0]
                                    : upperBlock[`KEY_WORD_BITS-1:0];

  // rotate left by one byte
  assign rotatedWord = {lastWord[23:0], lastWord[31:24]};
  assign subIn = advance ? rotatedWord : lastWord;

  subWord byteSub (
    .in (subIn),
    .out(subOut)
  );

  // constant sits in the top byte, folded in only on advancing steps
  assign mixWord = advance ? (subOut ^ {rconOut, 24'h000000}) : subOut;

  // ====================
  // xor chain
  // ====================
  always_comb begin
    newBlock[127:96] = upperBlock[127:96] ^ mixWord;
    newBlock[95:64]  = upperBlock[95:64]  ^ newBlock[127:96];
    newBlock[63:32]  = upperBlock[63:32]  ^ newBlock[95:64];
    newBlock[31:0]   = upperBlock[31:0]   ^ newBlock[63:32];
  end

  // 256-bit: shift the lower half up, append the new block below
  // 128-bit: new block replaces the upper half
  assign stepBus.nextWindow = stepBus.wideKey
    ? {stepBus.window[`KEY_BLOCK_BITS-1:0], newBlock}
    : {newBlock, {`KEY_BLOCK_BITS{1'b0}}};

endmodule

`default_nettype wire

//--- verilog/keySchedule.sv
// key-expansion sequencer: window, constant, phase, index, busy, credit counter, round-key output
`timescale 1ns/100ps
`default_nettype none

`include "keyExp_defs.svh"

module keySchedule (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   wideKey,
  input  keyExpPkg::keyMaterialT key,
  input  logic                   creditReturn,
  output keyExpPkg::blockT       roundKey,
  output logic                   roundKeyValid,
  output keyExpPkg::roundIndexT  roundIndex,
  output logic                   lastRoundKey,
  output logic                   busy,
  keyStepIf.sequencer            stepBus
);
  import keyExpPkg::*;

  localparam logic [`KEY_CREDIT_BITS-1:0] FullCredits = `KEY_CREDITS;

  keyMaterialT window;
  rconT rcon;
  keyPhaseT phase;
  logic wideFlag;
  logic [`KEY_CREDIT_BITS-1:0] credits;
  logic startAccept;
  logic emit;
  roundIndexT finalIndex;

  // new schedule only from idle
  assign startAccept = start && !busy;

  // one key per cycle while the consumer still has room
  assign emit = busy && (credits != '0);

  // last round-key number for the captured key length
  assign finalIndex = wideFlag ? roundIndexT'(`ROUNDS_256 - 1)
                               : roundIndexT'(`ROUNDS_128 - 1);

  // ====================
  // control state
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      roundIndex <= '0;
      rcon       <= `RCON_SEED;
      phase      <= rotPhase;
      wideFlag   <= 1'b0;
    end else if (startAccept) begin
      busy       <= 1'b1;
      roundIndex <= '0;
      rcon       <= `RCON_SEED;
      phase      <= rotPhase;
      wideFlag   <= wideKey;
    end else if (emit) begin
      roundIndex <= roundIndex + roundIndexT'(1);
      rcon       <= stepBus.nextRcon;
      // alternation only for the 256-bit schedule
      if (wideFlag) begin
        phase <= (phase == rotPhase) ? subPhase : rotPhase;
      end
      if (roundIndex == finalIndex) begin
        busy <= 1'b0;
      end
    end
  end

  // expansion window, loaded whole on start
  always_ff @(posedge clk) begin
    if (startAccept) begin
      window <= key;
    end else if (emit) begin
      window <= stepBus.nextWindow;
    end
  end

  // ====================
  // credit counter
  // ====================
  // spend on every shown key, refill on every returned credit
  always_ff @(posedge clk) begin
    if (reset || startAccept) begin
      credits <= FullCredits;
    end else begin
      case ({emit, creditReturn})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // state out to the round step
  assign stepBus.window  = window;
  assign stepBus.rcon    = rcon;
  assign stepBus.phase   = phase;
  assign stepBus.wideKey = wideFlag;

  // round key is always the upper half of the window
  assign roundKey      = window[`KEY_MAX_BITS-1 -: `KEY_BLOCK_BITS];
  assign roundKeyValid = emit;
  assign lastRoundKey  = emit && (roundIndex == finalIndex);

endmodule

`default_nettype wire

//--- verilog/keyExpand.sv
// AES encryption key-expansion top: schedule sequencer chained to the round-step logic
`timescale 1ns/100ps
`default_nettype none

module keyExpand (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   wideKey,
  input  keyExpPkg::keyMaterialT key,
  input  logic                   creditReturn,
  output keyExpPkg::blockT       roundKey,
  output logic                   roundKeyValid,
  output keyExpPkg::roundIndexT  roundIndex,
  output logic                   lastRoundKey,
  output logic                   busy
);

  // state out, next state back, same cycle
  keyStepIf stepBus ();

  // registers, credits and the round-key port
  keySchedule sequencerInst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .wideKey      (wideKey),
    .key          (key),
    .creditReturn (creditReturn),
    .roundKey     (roundKey),
    .roundKeyValid(roundKeyValid),
    .roundIndex   (roundIndex),
    .lastRoundKey (lastRoundKey),
    .busy         (busy),
    .stepBus      (stepBus.sequencer)
  );

  // pure combinational next-block logic
  keyStep stepInst (
    .stepBus(stepBus.step)
  );

endmodule

`default_nettype wire

//--- dv/keyExpand_properties.sv
// bound assertions on credit accounting, round-index stepping and state hold under back-pressure
`timescale 1ns/100ps
`default_nettype none

`include "keyExp_defs.svh"

module keyExpand_properties (
  input logic                        clk,
  input logic                        reset,
  input logic                        roundKeyValid,
  input logic                        lastRoundKey,
  input logic                        busy,
  input logic                        creditReturn,
  input logic [`KEY_CREDIT_BITS-1:0] credits,
  input keyExpPkg::roundIndexT       roundIndex,
  input keyExpPkg::keyMaterialT      window,
  input keyExpPkg::rconT             rcon
);
  import keyExpPkg::*;

  // keys shown and not yet paid back, as the consumer counts them
  logic [`KEY_CREDIT_BITS-1:0] unreturned;
  // number of the most recent shown key
  roundIndexT shownIndex;

  always_ff @(posedge clk) begin
    if (reset) begin
      unreturned <= '0;
    end else if (roundKeyValid && !creditReturn) begin
      unreturned <= unreturned + 1'b1;
    end else if (creditReturn && !roundKeyValid) begin
      unreturned <= unreturned - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      shownIndex <= '0;
    end else if (roundKeyValid) begin
      shownIndex <= roundIndex;
    end
  end

  // ====================
  // credit accounting
  // ====================
  creditGuard: assert property (@(posedge clk) disable iff (reset)
    roundKeyValid |-> unreturned < `KEY_CREDITS)
    else $error("round key shown with the whole credit grant outstanding");

  creditCeiling: assert property (@(posedge clk) disable iff (reset)
    credits <= `KEY_CREDITS)
    else $error("credit counter above the initial grant");

  // ====================
  // stepping and hold
  // ====================
  // each shown key after the first follows the previous shown one by one
  indexStep: assert property (@(posedge clk) disable iff (reset)
    roundKeyValid && roundIndex != '0 |-> roundIndex == roundIndexT'(shownIndex + 1))
    else $error("round index did not advance by one");

  // stalled schedule keeps its whole state
  stallHold: assert property (@(posedge clk) disable iff (reset)
    busy && !roundKeyValid |=> $stable(window) && $stable(rcon) && $stable(roundIndex))
    else $error("expansion state moved without a shown key");

endmodule

bind keySchedule keyExpand_properties propsCheck (
  .clk          (clk),
  .reset        (reset),
  .roundKeyValid(roundKeyValid),
  .lastRoundKey (lastRoundKey),
  .busy         (busy),
  .creditReturn (creditReturn),
  .credits      (credits),
  .roundIndex   (roundIndex),
  .window       (window),
  .rcon         (rcon)
);

`default_nettype wire

//--- dv/keyExpand_tb.sv
// testbench for the AES key expansion: stimulus, software key schedule, compare process, report
`timescale 1ns/100ps
`default_nettype none

`include "keyExp_defs.svh"

module keyExpand_tb;
  import keyExpPkg::*;

  logic clk = 1'b0;
  logic reset, start, wideKey, creditReturn;
  keyMaterialT key;
  blockT roundKey;
  logic roundKeyValid, lastRoundKey, busy;
  roundIndexT roundIndex;

  logic [7:0] sboxTable [256];
  logic [31:0] lcgState = 32'd26;
  blockT expKeys[$];
  int expIndex[$];
  bit expLast[$];
  string testName = "reset";
  int errorCount = 0, checkCount = 0, receivedCount = 0, outstanding = 0;
  int cycleCount = 0, lastValidCycle = 0, holdoff = 0, creditMode = 0;
  bit spacingCheck = 0;
  int seen;
  keyMaterialT fips128, fips256;

  keyExpand dut_i (
    .clk(clk), .reset(reset), .start(start), .wideKey(wideKey), .key(key),
    .creditReturn(creditReturn), .roundKey(roundKey), .roundKeyValid(roundKeyValid),
    .roundIndex(roundIndex), .lastRoundKey(lastRoundKey), .busy(busy)
  );

  always #50 clk = ~clk;

  function logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // ====================
  // software reference
  // ====================
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p ^= x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // field inverse by search, then the affine map
  function automatic logic [7:0] sboxEntry(input logic [7:0] v);
    logic [7:0] inv;
    inv = 8'h00;
    for (int c = 1; c < 256; c++) begin
      if (gfMul(v, 8'(c)) == 8'h01) inv = 8'(c);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  function automatic wordT subWordRef(input wordT w);
    return {sboxTable[w[31:24]], sboxTable[w[23:16]], sboxTable[w[15:8]], sboxTable[w[7:0]]};
  endfunction

  // full FIPS-197 schedule, returns round key idx
  function automatic blockT refRoundKey(input keyMaterialT k, input bit wide, input int idx);
    wordT w [60];
    wordT temp;
    logic [7:0] rc;
    int nk;
    nk = wide ? 8 : 4;
    rc = 8'h01;
    for (int i = 0; i < 60; i++) begin
      if (i < nk) begin
        w[i] = k[255-32*i -: 32];
      end else begin
        temp = w[i-1];
        if (i % nk == 0) begin
          temp = subWordRef({temp[23:0], temp[31:24]}) ^ {rc, 24'h000000};
          rc = gfMul(rc, 8'h02);
        end else if (nk == 8 && i % nk == 4) begin
          temp = subWordRef(temp);
        end
        w[i] = w[i-nk] ^ temp;
      end
    end
    return {w[4*idx], w[4*idx+1], w[4*idx+2], w[4*idx+3]};
  endfunction

  function automatic keyMaterialT randomKey(input bit wide);
    keyMaterialT k;
    for (int i = 0; i < 8; i++) k[255-32*i -: 32] = lcgNext();
    if (!wide) k[127:0] = '0;
    return k;
  endfunction

  task automatic checkValue(input string what, input logic [127:0] expected, actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  // ====================
  // compare and credit return
  // ====================
  always @(posedge clk) begin
    cycleCount++;
    if (reset) begin
      outstanding = 0;
      creditReturn <= 1'b0;
    end else begin
      if (creditReturn) outstanding--;
      if (roundKeyValid) begin
        if (expKeys.size() == 0) begin
          errorCount++;
          $display("%s: round key %0d arrived with no schedule pending", testName, roundIndex);
        end else begin
          checkValue("round key", expKeys.pop_front(), roundKey);
          checkValue("round index", expIndex.pop_front(), roundIndex);
          checkValue("last flag", expLast.pop_front(), lastRoundKey);
          if (spacingCheck && roundIndex != 0)
            checkValue("key spacing", 1, cycleCount - lastValidCycle);
        end
        lastValidCycle = cycleCount;
        receivedCount++;
        outstanding++;
      end
      if (outstanding > `KEY_CREDITS) begin
        errorCount++;
        $display("%s: %0d round keys outstanding, above the credit grant", testName, outstanding);
      end
      if (holdoff > 0) holdoff--;
      // mode 0 returns at once, 1 after a random pause, 2 withholds
      if (creditMode != 2 && outstanding > 0 && holdoff == 0) begin
        creditReturn <= 1'b1;
        if (creditMode == 1) holdoff = (lcgNext() >> 16) % 4;
      end else begin
        creditReturn <= 1'b0;
      end
    end
  end

  // ====================
  // stimulus tasks
  // ====================
  task automatic waitIdle();
    int cycles = 0;
    while ((busy || outstanding != 0) && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (busy || outstanding != 0) begin
      errorCount++;
      $display("%s: engine or credits never went idle", testName);
    end
  endtask

  task automatic launch(input keyMaterialT k, input bit wide, input bit spacing);
    int n;
    n = wide ? `ROUNDS_256 : `ROUNDS_128;
    waitIdle();
    for (int i = 0; i < n; i++) begin
      expKeys.push_back(refRoundKey(k, wide, i));
      expIndex.push_back(i);
      expLast.push_back(i == n - 1);
    end
    spacingCheck = spacing;
    @(posedge clk);
    start <= 1'b1;
    wideKey <= wide;
    key <= k;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic waitDone();
    int cycles = 0;
    while ((expKeys.size() != 0 || busy) && cycles < 400) begin
      @(negedge clk);
      cycles++;
    end
    if (expKeys.size() != 0 || busy) begin
      errorCount++;
      $display("%s: schedule did not finish, %0d keys missing", testName, expKeys.size());
    end
  endtask

  initial begin
    int cycles;
    bit wide;
    start = 1'b0;
    wideKey = 1'b0;
    key = '0;
    creditReturn = 1'b0;
    reset = 1'b1;
    for (int i = 0; i < 256; i++) sboxTable[i] = sboxEntry(8'(i));
    fips128 = {128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h0};
    fips256 = 256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkValue("valid", 0, roundKeyValid);
    checkValue("last", 0, lastRoundKey);
    checkValue("busy", 0, busy);
    checkValue("index", 0, roundIndex);

    // published vectors pin the reference itself
    testName = "fips128";
    checkValue("ref key 1", 128'ha0fafe1788542cb123a339392a6c7605, refRoundKey(fips128, 0, 1));
    checkValue("ref key 10", 128'hd014f9a8c9ee2589e13f0cc8b6630ca6, refRoundKey(fips128, 0, 10));
    launch(fips128, 0, 1);
    waitDone();
    testName = "fips256";
    checkValue("ref key 14", 128'hfe4890d1e6188d0b046df344706c631e, refRoundKey(fips256, 1, 14));
    launch(fips256, 1, 1);
    waitDone();

    testName = "random back-to-back";
    for (int t = 0; t < 20; t++) begin
      wide = lcgNext() >> 31;
      launch(randomKey(wide), wide, 1);
      waitDone();
    end

    testName = "random credit delay";
    creditMode = 1;
    for (int t = 0; t < 6; t++) begin
      wide = lcgNext() >> 31;
      launch(randomKey(wide), wide, 0);
      waitDone();
    end
    // late credit returns drain first
    waitIdle();

    // stall with no credits back, then release
    testName = "credits withheld";
    creditMode = 2;
    launch(randomKey(1), 1, 0);
    cycles = 0;
    while (outstanding < `KEY_CREDITS && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (outstanding < `KEY_CREDITS) begin
      errorCount++;
      $display("%s: credit grant was never used up", testName);
    end
    seen = receivedCount;
    repeat (20) @(negedge clk);
    checkValue("keys during stall", seen, receivedCount);
    checkValue("busy during stall", 1, busy);
    creditMode = 0;
    waitDone();

    testName = "start while busy";
    seen = receivedCount;
    launch(randomKey(0), 0, 1);
    cycles = 0;
    while (receivedCount < seen + 3 && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (receivedCount < seen + 3) begin
      errorCount++;
      $display("%s: first round keys never arrived", testName);
    end
    @(posedge clk);
    start <= 1'b1;
    wideKey <= 1'b1;
    key <= randomKey(1);
    @(posedge clk);
    start <= 1'b0;
    waitDone();
    waitIdle();

    $display("errors: %0d, checks: %0d", errorCount, checkCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/keyExpPkg.sv
verilog/keyStepIf.sv
verilog/subWord.sv
verilog/keyStep.sv
verilog/keySchedule.sv
verilog/keyExpand.sv
dv/keyExpand_properties.sv
dv/keyExpand_tb.sv
